/* hdl/apb_fabric_cfg.svh */
`ifndef APB_FABRIC_CFG_SVH
`define APB_FABRIC_CFG_SVH

// number of completer ports behind the fabric
`define FAB_NS 4

// APB address and data widths
`define FAB_AW 16
`define FAB_DW 32

// completer base addresses, completer 0 in the low 16 bits
// 0: 0x0000-0x0fff, 1: 0x1000-0x1fff, 2: 0x2000-0x3fff, 3: 0x4000-0x7fff
`define FAB_SLAVE_ADDR {16'h4000, 16'h2000, 16'h1000, 16'h0000}

// address bits compared against each base, same packing as the bases
`define FAB_SLAVE_MASK {16'hc000, 16'he000, 16'hf000, 16'hf000}

// one bit per completer, set where writes are allowed
// completer 3 is read only
`define FAB_WRITE_OK 4'b0111

// decoder registers its outputs when set
// costs one cycle but breaks the compare path
`define FAB_DECODE_REG 1'b1

`endif

/* hdl/apb_fabric_pkg.sv */
`default_nettype none

`include "apb_fabric_cfg.svh"

package apb_fabric_pkg;

	// requester to completer signals of one APB port
	typedef struct packed {
		logic                 psel;
		logic                 penable;
		logic                 pwrite;
		logic [`FAB_AW-1:0]   paddr;
		logic [`FAB_DW-1:0]   pwdata;
	} apb_req_t;

	// completer to requester signals of one APB port
	typedef struct packed {
		logic                 pready;
		logic [`FAB_DW-1:0]   prdata;
		logic                 pslverr;
	} apb_rsp_t;

	// transfer as captured from the requester
	typedef struct packed {
		logic [`FAB_AW-1:0]   addr;
		logic [`FAB_DW-1:0]   wdata;
		logic                 write;
	} xfer_t;

	// outcome handed back to the requester side
	typedef struct packed {
		logic [`FAB_DW-1:0]   rdata;
		logic                 err;
	} result_t;

	// one-hot completer select, top bit means no permitted completer
	typedef logic [`FAB_NS:0] sel_t;

endpackage

`default_nettype wire

/* hdl/apb_req_intake.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_fabric_cfg.svh"

module apb_req_intake (
	input  wire                          i_clk,
	input  wire                          i_reset,
	input  wire apb_fabric_pkg::apb_req_t i_m_req,
	output apb_fabric_pkg::apb_rsp_t     o_m_rsp,
	output logic                         o_xfer_valid,
	output apb_fabric_pkg::xfer_t        o_xfer,
	input  wire                          i_xfer_stall,
	input  wire                          i_res_valid,
	input  wire apb_fabric_pkg::result_t i_res
);

	// idle: waiting for an access phase
	// issued: request offered downstream
	// waiting: request taken, result pending
	typedef enum logic [1:0] {S_IDLE, S_ISSUED, S_WAITING} state_t;

	state_t                  state;
	logic                    access_start;
	logic                    r_pready;
	logic [`FAB_DW-1:0]      r_rdata;
	logic                    r_err;
	apb_fabric_pkg::xfer_t   r_xfer;

	// first access cycle of a new transfer
	// the pready cycle still shows the old access, so skip it
	assign access_start = (state == S_IDLE) && i_m_req.psel && i_m_req.penable && !r_pready;

	always_ff @(posedge i_clk)
		if (i_reset)
			state <= S_IDLE;
		else
			case (state)
			S_IDLE:    if (access_start) state <= S_ISSUED;
			S_ISSUED:  if (!i_xfer_stall) state <= S_WAITING;
			S_WAITING: if (i_res_valid) state <= S_IDLE;
			default:   state <= S_IDLE;
			endcase

	// requester holds address and data through the access phase
	always_ff @(posedge i_clk)
		if (access_start)
		begin
			r_xfer.addr  <= i_m_req.paddr;
			r_xfer.wdata <= i_m_req.pwdata;
			r_xfer.write <= i_m_req.pwrite;
		end

	// single pready pulse, read data and error zero outside of it
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			r_pready <= 1'b0;
			r_rdata  <= '0;
			r_err    <= 1'b0;
		end
		else
		begin
			r_pready <= (state == S_WAITING) && i_res_valid;
			r_rdata  <= ((state == S_WAITING) && i_res_valid) ? i_res.rdata : '0;
			r_err    <= (state == S_WAITING) && i_res_valid && i_res.err;
		end

	assign o_m_rsp.pready  = r_pready;
	assign o_m_rsp.prdata  = r_rdata;
	assign o_m_rsp.pslverr = r_err;
	assign o_xfer_valid    = (state == S_ISSUED);
	assign o_xfer          = r_xfer;

	// the requester must still be in its access phase when we complete
	a_pready_in_access: assert property (@(posedge i_clk) disable iff (i_reset)
		o_m_rsp.pready |-> (i_m_req.psel && i_m_req.penable));

endmodule

`default_nettype wire

/* hdl/addr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_fabric_cfg.svh"

module addr_decode #(
	parameter int             NS             = `FAB_NS,
	parameter int             AW             = `FAB_AW,
	parameter int             DW             = `FAB_DW,
	parameter logic [NS*AW-1:0] SLAVE_ADDR   = `FAB_SLAVE_ADDR,
	parameter logic [NS*AW-1:0] SLAVE_MASK   = `FAB_SLAVE_MASK,
	parameter logic [NS-1:0]  WRITE_OK       = `FAB_WRITE_OK,
	parameter logic [0:0]     OPT_REGISTERED = `FAB_DECODE_REG
) (
	input  wire                        i_clk,
	input  wire                        i_reset,
	input  wire                        i_valid,
	output logic                       o_stall,
	input  wire apb_fabric_pkg::xfer_t i_xfer,
	output logic                       o_valid,
	input  wire                        i_stall,
	output apb_fabric_pkg::sel_t       o_sel,
	output apb_fabric_pkg::xfer_t      o_xfer
);

	logic [NS-1:0]          hit;
	apb_fabric_pkg::sel_t   request;

	// masked compare per completer, writes only where allowed
	always_comb
		for (int k = 0; k < NS; k++)
			hit[k] = (((i_xfer.addr ^ SLAVE_ADDR[k*AW +: AW]) & SLAVE_MASK[k*AW +: AW]) == '0)
				&& (!i_xfer.write || WRITE_OK[k]);

	// nothing hit, or a write to a read-only completer
	always_comb
	begin
		request[NS-1:0] = hit;
		request[NS]     = (hit == '0);
	end

	if (OPT_REGISTERED)
	begin : g_registered
		logic                  r_valid;
		apb_fabric_pkg::sel_t  r_sel;
		logic [AW-1:0]         r_addr;
		logic [DW-1:0]         r_wdata;
		logic                  r_write;

		// stall only when holding an item the next stage refuses
		assign o_stall = r_valid && i_stall;

		always_ff @(posedge i_clk)
			if (i_reset)
			begin
				r_valid <= 1'b0;
				r_sel   <= '0;
			end
			else if (!o_stall)
			begin
				r_valid <= i_valid;
				// clear the select once drained
				r_sel   <= i_valid ? request : '0;
			end

		always_ff @(posedge i_clk)
			if (!o_stall && i_valid)
			begin
				r_addr  <= i_xfer.addr;
				r_wdata <= i_xfer.wdata;
				r_write <= i_xfer.write;
			end

		always_comb
		begin
			o_valid      = r_valid;
			o_sel        = r_sel;
			o_xfer.addr  = r_addr;
			o_xfer.wdata = r_wdata;
			o_xfer.write = r_write;
		end
	end
	else
	begin : g_combinational
		// zero-cycle path, flow control passes straight through
		always_comb
		begin
			o_valid = i_valid;
			o_stall = i_stall;
			o_sel   = request;
			o_xfer  = i_xfer;
		end
	end

	a_sel_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
		o_valid |-> $onehot(o_sel));

endmodule

`default_nettype wire

/* hdl/apb_port_drive.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_fabric_cfg.svh"

module apb_port_drive (
	input  wire                                   i_clk,
	input  wire                                   i_reset,
	input  wire                                   i_valid,
	output logic                                  o_stall,
	input  wire apb_fabric_pkg::sel_t             i_sel,
	input  wire apb_fabric_pkg::xfer_t            i_xfer,
	output apb_fabric_pkg::apb_req_t [`FAB_NS-1:0] o_s_req,
	input  wire apb_fabric_pkg::apb_rsp_t [`FAB_NS-1:0] i_s_rsp,
	output logic                                  o_res_valid,
	output apb_fabric_pkg::result_t               o_res
);

	localparam int NS = `FAB_NS;

	// setup and access follow APB, done presents the result for one cycle
	typedef enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS, S_DONE} state_t;

	state_t                    state;
	logic                      accept;
	logic                      none_sel;
	logic [NS-1:0]             r_sel;
	apb_fabric_pkg::xfer_t     r_xfer;
	apb_fabric_pkg::result_t   r_res;
	logic [NS-1:0]             s_psel;
	logic                      sel_ready;
	logic [`FAB_DW-1:0]        sel_rdata;
	logic                      sel_err;

	assign accept   = i_valid && (state == S_IDLE);
	// no completer matched, or the decoder refused a write
	assign none_sel = i_sel[NS];

	always_ff @(posedge i_clk)
		if (i_reset)
			state <= S_IDLE;
		else
			case (state)
			S_IDLE:   if (i_valid) state <= none_sel ? S_DONE : S_SETUP;
			S_SETUP:  state <= S_ACCESS;
			S_ACCESS: if (sel_ready) state <= S_DONE;
			S_DONE:   state <= S_IDLE;
			default:  state <= S_IDLE;
			endcase

	// select and transfer held from setup until completion
	always_ff @(posedge i_clk)
		if (accept)
		begin
			r_sel  <= i_sel[NS-1:0];
			r_xfer <= i_xfer;
		end

	// error result preset on accept, real response replaces it at pready
	always_ff @(posedge i_clk)
		if (accept)
		begin
			r_res.rdata <= '0;
			r_res.err   <= 1'b1;
		end
		else if ((state == S_ACCESS) && sel_ready)
		begin
			r_res.rdata <= sel_rdata;
			r_res.err   <= sel_err;
		end

	// response of the selected completer only
	always_comb
	begin
		sel_ready = 1'b0;
		sel_rdata = '0;
		sel_err   = 1'b0;
		for (int k = 0; k < NS; k++)
			if (r_sel[k])
			begin
				sel_ready = sel_ready | i_s_rsp[k].pready;
				sel_rdata = sel_rdata | i_s_rsp[k].prdata;
				sel_err   = sel_err | i_s_rsp[k].pslverr;
			end
	end

	// psel routed to one port, address and data shared by all
	always_comb
		for (int k = 0; k < NS; k++)
		begin
			s_psel[k]          = r_sel[k] && ((state == S_SETUP) || (state == S_ACCESS));
			o_s_req[k].psel    = s_psel[k];
			o_s_req[k].penable = r_sel[k] && (state == S_ACCESS);
			o_s_req[k].pwrite  = r_xfer.write;
			o_s_req[k].paddr   = r_xfer.addr;
			o_s_req[k].pwdata  = r_xfer.wdata;
		end

	// busy from accept until the result has gone out
	assign o_stall     = (state != S_IDLE);
	assign o_res_valid = (state == S_DONE);
	assign o_res       = r_res;

	a_psel_onehot0: assert property (@(posedge i_clk) disable iff (i_reset)
		$onehot0(s_psel));

endmodule

`default_nettype wire

/* hdl/apb_fabric_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_fabric_cfg.svh"

module apb_fabric_top (
	input  wire                                   i_clk,
	input  wire                                   i_reset,
	input  wire apb_fabric_pkg::apb_req_t         i_m_req,
	output apb_fabric_pkg::apb_rsp_t              o_m_rsp,
	output apb_fabric_pkg::apb_req_t [`FAB_NS-1:0] o_s_req,
	input  wire apb_fabric_pkg::apb_rsp_t [`FAB_NS-1:0] i_s_rsp
);

	// intake to decoder
	logic                     xfer_valid;
	logic                     xfer_stall;
	apb_fabric_pkg::xfer_t    xfer;

	// decoder to port driver
	logic                     dec_valid;
	logic                     dec_stall;
	apb_fabric_pkg::sel_t     dec_sel;
	apb_fabric_pkg::xfer_t    dec_xfer;

	// port driver back to intake
	logic                     res_valid;
	apb_fabric_pkg::result_t  res;

	apb_req_intake u_intake (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_m_req(i_m_req), .o_m_rsp(o_m_rsp),
		.o_xfer_valid(xfer_valid), .o_xfer(xfer), .i_xfer_stall(xfer_stall),
		.i_res_valid(res_valid), .i_res(res)
	);

	addr_decode #(.OPT_REGISTERED(`FAB_DECODE_REG)) u_decode (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_valid(xfer_valid), .o_stall(xfer_stall), .i_xfer(xfer),
		.o_valid(dec_valid), .i_stall(dec_stall), .o_sel(dec_sel), .o_xfer(dec_xfer)
	);

	apb_port_drive u_port (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_valid(dec_valid), .o_stall(dec_stall), .i_sel(dec_sel), .i_xfer(dec_xfer),
		.o_s_req(o_s_req), .i_s_rsp(i_s_rsp),
		.o_res_valid(res_valid), .o_res(res)
	);

endmodule

`default_nettype wire

/* tb/apb_tb_completer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_fabric_cfg.svh"

module apb_tb_completer #(
	parameter bit READ_ONLY = 1'b0
) (
	input  wire                           i_clk,
	input  wire                           i_reset,
	input  wire apb_fabric_pkg::apb_req_t i_req,
	output apb_fabric_pkg::apb_rsp_t      o_rsp
);

	// 64 words, indexed by address bits 7:2
	logic [`FAB_DW-1:0]  mem [0:63];
	logic [5:0]          word;
	int unsigned         wait_cnt;

	assign word = i_req.paddr[7:2];

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			o_rsp    <= '0;
			wait_cnt <= 0;
			for (int i = 0; i < 64; i++)
				mem[i] <= '0;
		end
		else
		begin
			// response lasts one cycle, data zero outside of it
			o_rsp <= '0;
			// setup phase picks the number of wait states
			if (i_req.psel && !i_req.penable)
				wait_cnt <= $urandom_range(3, 0);
			else if (i_req.psel && i_req.penable && !o_rsp.pready)
			begin
				if (wait_cnt != 0)
					wait_cnt <= wait_cnt - 1;
				else
				begin
					o_rsp.pready <= 1'b1;
					// read-only data is derived from the address
					if (READ_ONLY && !i_req.pwrite)
						o_rsp.prdata <= {{(`FAB_DW-`FAB_AW){1'b0}}, i_req.paddr} ^ 32'hA5A5_0000;
					else if (!i_req.pwrite)
						o_rsp.prdata <= mem[word];
					else if (!READ_ONLY)
						mem[word] <= i_req.pwdata;
				end
			end
		end

endmodule

`default_nettype wire

/* tb/apb_fabric_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "apb_fabric_cfg.svh"

module apb_fabric_tb;

	localparam int NS      = `FAB_NS;
	localparam int TIMEOUT = 200;
	// one address per region, last one has no completer
	localparam logic [`FAB_AW-1:0] BASES [NS+1] =
		'{16'h0000, 16'h1000, 16'h2000, 16'h4000, 16'h8000};

	logic                                clk = 1'b0;
	logic                                reset;
	apb_fabric_pkg::apb_req_t            m_req;
	apb_fabric_pkg::apb_rsp_t            m_rsp;
	apb_fabric_pkg::apb_req_t [NS-1:0]   s_req;
	apb_fabric_pkg::apb_rsp_t [NS-1:0]   s_rsp;

	// reference model of the completer memories
	logic [`FAB_DW-1:0]        model_mem [NS][64];
	// port expected to see the running transfer, -1 for none
	int                        exp_port = -1;
	apb_fabric_pkg::apb_req_t  exp_req;
	logic                      port_in_access;
	logic                      port_done;

	always #4 clk = ~clk;

	apb_fabric_top UUT (
		.i_clk(clk), .i_reset(reset),
		.i_m_req(m_req), .o_m_rsp(m_rsp),
		.o_s_req(s_req), .i_s_rsp(s_rsp)
	);

	// completer 3 is the read-only one
	for (genvar k = 0; k < NS; k++)
	begin : g_comp
		apb_tb_completer #(.READ_ONLY(k == NS - 1)) u_comp (
			.i_clk(clk), .i_reset(reset), .i_req(s_req[k]), .o_rsp(s_rsp[k])
		);
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_result(input apb_fabric_pkg::result_t got,
		input apb_fabric_pkg::result_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Error at time %0t: %s gave rdata %h err %b, expected %h err %b",
				$time, what, got.rdata, got.err, exp.rdata, exp.err));
	endtask

	task automatic check_req(input apb_fabric_pkg::apb_req_t got,
		input apb_fabric_pkg::apb_req_t exp, input int port);
		if (got !== exp)
			stop_run($sformatf("Error at time %0t: completer %0d saw request %h, expected %h",
				$time, port, got, exp));
	endtask

	// completer that owns each address range, -1 above the map
	function automatic int port_of_addr(input logic [`FAB_AW-1:0] addr);
		if (addr < 16'h1000)
			return 0;
		else if (addr < 16'h2000)
			return 1;
		else if (addr < 16'h4000)
			return 2;
		else if (addr < 16'h8000)
			return 3;
		return -1;
	endfunction

	// completer ports and idle response, checked mid cycle
	always @(negedge clk)
	begin
		logic                     any_psel;
		apb_fabric_pkg::apb_req_t want;
		apb_fabric_pkg::result_t  idle_rsp;
		any_psel = 1'b0;
		if (!reset)
		begin
			for (int k = 0; k < NS; k++)
				if (s_req[k].psel)
				begin
					if (k != exp_port)
						stop_run($sformatf("Error at time %0t: completer %0d selected, expected %0d",
							$time, k, exp_port));
					// first psel cycle is setup, the rest are access
					want = exp_req;
					want.penable = port_in_access;
					check_req(s_req[k], want, k);
					any_psel = 1'b1;
					if (s_req[k].penable && s_rsp[k].pready)
						port_done = 1'b1;
				end
			port_in_access = any_psel;
			if (m_rsp.pready && !(m_req.psel && m_req.penable))
				stop_run("pready went high while the requester was not in an access phase");
			if (!m_rsp.pready)
			begin
				idle_rsp = {m_rsp.prdata, m_rsp.pslverr};
				check_result(idle_rsp, '0, "idle response");
			end
		end
	end

	task automatic run_transfer(input logic write, input logic [`FAB_AW-1:0] addr,
		input logic [`FAB_DW-1:0] wdata);
		int                      port;
		int                      cycles;
		apb_fabric_pkg::result_t exp;
		apb_fabric_pkg::result_t got;
		port = port_of_addr(addr);
		// no completer, or a write to the read-only one
		exp.err   = (port < 0) || (write && port == NS - 1);
		exp.rdata = '0;
		if (!exp.err && !write)
			exp.rdata = (port == NS - 1) ?
				({{(`FAB_DW-`FAB_AW){1'b0}}, addr} ^ 32'hA5A5_0000) : model_mem[port][addr[7:2]];
		if (!exp.err && write)
			model_mem[port][addr[7:2]] = wdata;
		exp_req        = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		exp_port       = exp.err ? -1 : port;
		port_in_access = 1'b0;
		port_done      = 1'b0;
		@(posedge clk);
		m_req <= exp_req;
		@(posedge clk);
		m_req.penable <= 1'b1;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				stop_run($sformatf("transfer to address %h timed out waiting for pready", addr));
		end
		while (!m_rsp.pready);
		got.rdata = m_rsp.prdata;
		got.err   = m_rsp.pslverr;
		check_result(got, exp, $sformatf("transfer to %h", addr));
		if (exp_port >= 0 && !port_done)
			stop_run("requester saw pready before the completer had responded");
		@(posedge clk);
		m_req    <= '0;
		exp_port = -1;
	endtask

	initial
	begin
		logic [31:0]         rnd;
		logic [`FAB_AW-1:0]  addr;
		int                  region;
		void'($urandom(32'h8176_8142));
		reset = 1'b1;
		m_req = '0;
		for (int p = 0; p < NS; p++)
			for (int w = 0; w < 64; w++)
				model_mem[p][w] = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		// quiet bus before the first transfer
		repeat (4)
		begin
			@(negedge clk);
			if (m_rsp.pready || (s_req[0].psel | s_req[1].psel | s_req[2].psel | s_req[3].psel))
				stop_run("pready or a completer psel is high after reset");
		end
		// write then read back in every region
		for (int k = 0; k <= NS; k++)
		begin
			run_transfer(1'b1, BASES[k] | 16'h0010, 32'hC0DE_0000 | 32'(k));
			run_transfer(1'b0, BASES[k] | 16'h0010, '0);
		end
		// random mix over few words so reads hit earlier writes
		repeat (400)
		begin
			rnd       = $urandom();
			region    = $urandom_range(4, 0);
			addr      = rnd[15:0];
			addr[7:2] = {3'b000, rnd[18:16]};
			addr[1:0] = 2'b00;
			case (region)
			0:       addr[15:12] = 4'h0;
			1:       addr[15:12] = 4'h1;
			2:       addr[15:13] = 3'b001;
			3:       addr[15:14] = 2'b01;
			default: addr[15] = 1'b1;
			endcase
			run_transfer(rnd[20], addr, $urandom());
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/apb_fabric_pkg.sv
hdl/apb_req_intake.sv
hdl/addr_decode.sv
hdl/apb_port_drive.sv
hdl/apb_fabric_top.sv
tb/apb_tb_completer.sv
tb/apb_fabric_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the APB fabric testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=apb_fabric_sim

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module apb_fabric_tb -f vlog.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	echo "simulation log reports a failure"
	exit 1
fi

echo "simulation log is clean"
exit 0
